/* filelist.f */
rv32_isa_pkg.sv
cluster_pkg.sv
bram_dual_re.sv
rv32im_registers.sv
regfile_arbiter.sv
alu_lane.sv
rv32_regfile_cluster.sv
tb_cluster.sv

/* Makefile */
# Verilator build and run for the RV32IM register file cluster

SIM       ?= verilator
TOP       ?= tb_cluster
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert
PASS_TEXT ?= ALL CHECKS PASSED

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* tb_cluster.sv */
`default_nettype none

module tb_cluster;

  localparam int unsigned n_random   = 300;
  localparam int unsigned wait_limit = 2000;
  localparam int unsigned run_limit  = 200000;

  typedef enum int {
    op_add, op_sub, op_and, op_or, op_xor, op_sll, op_srl, op_mul,
    op_addi, op_andi, op_ori, op_xori
  } op_e;

  logic                                clk_i;
  logic                                rst_n_i;
  logic [cluster_pkg::num_lanes-1:0]   instr_valid_i;
  rv32_isa_pkg::instr_u                instr_i [cluster_pkg::num_lanes];
  logic [cluster_pkg::num_lanes-1:0]   instr_credit_o;
  logic [cluster_pkg::num_lanes-1:0]   result_valid_o;
  cluster_pkg::result_t                result_o [cluster_pkg::num_lanes];
  logic [cluster_pkg::num_lanes-1:0]   result_credit_i;

  // reference register values and expected results per lane
  logic [rv32_isa_pkg::xlen-1:0] regs [rv32_isa_pkg::num_regs];
  cluster_pkg::result_t          want_q [cluster_pkg::num_lanes][$];
  logic [31:0]                   rng_state;
  // credit and traffic bookkeeping
  int in_cred [cluster_pkg::num_lanes];
  int res_cred [cluster_pkg::num_lanes];
  int pushed [cluster_pkg::num_lanes];
  int popped [cluster_pkg::num_lanes];
  int received [cluster_pkg::num_lanes];
  int planned [cluster_pkg::num_lanes];
  int owed [cluster_pkg::num_lanes];
  logic lane_done [cluster_pkg::num_lanes];
  int errors;
  int checks;
  int timeouts;

  rv32_regfile_cluster dut_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .instr_valid_i   (instr_valid_i),
    .instr_i         (instr_i),
    .instr_credit_o  (instr_credit_o),
    .result_valid_o  (result_valid_o),
    .result_o        (result_o),
    .result_credit_i (result_credit_i)
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  // xorshift32
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // register from the lane's bank, x0 now and then
  function automatic logic [4:0] pick_reg(input int lane, input int x0_odds);
    logic [4:0] base;
    int span;
    base = (lane == 0) ? 5'd1 : 5'd16;
    span = (lane == 0) ? 15 : 16;
    if (next_rand() % x0_odds == 0) begin
      return 5'd0;
    end
    return 5'(base + next_rand() % span);
  endfunction

  // build the instruction word through the union
  function automatic rv32_isa_pkg::instr_u encode(input op_e op, input logic [4:0] rd,
                                                   input logic [4:0] rs1, input logic [4:0] rs2,
                                                   input logic [11:0] imm);
    rv32_isa_pkg::instr_u w;
    w.raw = '0;
    if (op >= op_addi) begin
      w.i.opcode = rv32_isa_pkg::op_imm;
      w.i.rd     = rd;
      w.i.rs1    = rs1;
      w.i.imm12  = imm;
      case (op)
        op_addi: w.i.funct3 = rv32_isa_pkg::f3_add_sub;
        op_andi: w.i.funct3 = rv32_isa_pkg::f3_and;
        op_ori:  w.i.funct3 = rv32_isa_pkg::f3_or;
        default: w.i.funct3 = rv32_isa_pkg::f3_xor;
      endcase
    end else begin
      w.r.opcode = rv32_isa_pkg::op_reg;
      w.r.rd     = rd;
      w.r.rs1    = rs1;
      w.r.rs2    = rs2;
      case (op)
        op_sub:  w.r.funct7 = rv32_isa_pkg::f7_sub;
        op_mul:  w.r.funct7 = rv32_isa_pkg::f7_muldiv;
        default: w.r.funct7 = 7'd0;
      endcase
      case (op)
        op_and:  w.r.funct3 = rv32_isa_pkg::f3_and;
        op_or:   w.r.funct3 = rv32_isa_pkg::f3_or;
        op_xor:  w.r.funct3 = rv32_isa_pkg::f3_xor;
        op_sll:  w.r.funct3 = rv32_isa_pkg::f3_sll;
        op_srl:  w.r.funct3 = rv32_isa_pkg::f3_srl;
        op_mul:  w.r.funct3 = rv32_isa_pkg::f3_mul;
        default: w.r.funct3 = rv32_isa_pkg::f3_add_sub;
      endcase
    end
    return w;
  endfunction

  // ISA semantics, b is rs2 for R-type
  function automatic logic [31:0] expect_value(input op_e op, input logic [31:0] a,
                                                input logic [31:0] b, input logic [11:0] imm);
    logic [31:0] sx;
    logic [63:0] prod;
    logic [31:0] res;
    sx   = {{20{imm[11]}}, imm};
    prod = {32'd0, a} * {32'd0, b};
    case (op)
      op_add:  res = a + b;
      op_sub:  res = a - b;
      op_and:  res = a & b;
      op_or:   res = a | b;
      op_xor:  res = a ^ b;
      // shift amount is rs2[4:0] only
      op_sll:  res = a << b[4:0];
      op_srl:  res = a >> b[4:0];
      op_mul:  res = prod[31:0];
      op_addi: res = a + sx;
      op_andi: res = a & sx;
      op_ori:  res = a | sx;
      default: res = a ^ sx;
    endcase
    return res;
  endfunction

  // wait for a credit, update the model, drive one cycle of valid
  task automatic issue_one(input int lane, input op_e op, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [4:0] rs2,
                           input logic [11:0] imm, output logic ok);
    cluster_pkg::result_t r;
    int waited;
    waited = 0;
    while (in_cred[lane] == 0 && waited < wait_limit) begin
      @(posedge clk_i);
      waited++;
    end
    ok = (in_cred[lane] != 0);
    if (!ok) begin
      $display("timeout: lane %0d never got an instruction credit back", lane);
      timeouts++;
    end else begin
      r.rd    = rd;
      r.value = expect_value(op, regs[rs1], regs[rs2], imm);
      // x0 stays zero in the model
      if (rd != 5'd0) begin
        regs[rd] = r.value;
      end
      want_q[lane].push_back(r);
      @(posedge clk_i);
      instr_valid_i[lane] <= 1'b1;
      instr_i[lane]       <= encode(op, rd, rs1, rs2, imm);
      in_cred[lane]--;
      pushed[lane]++;
      @(posedge clk_i);
      instr_valid_i[lane] <= 1'b0;
    end
  endtask

  task automatic issue_lane(input int lane);
    logic ok;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [11:0] imm;
    op_e op;
    int gap;
    int span;
    ok   = 1'b1;
    span = (lane == 0) ? 15 : 16;
    // seed the whole bank from x0
    for (int k = 0; k < span && ok; k++) begin
      rd  = (lane == 0) ? 5'(1 + k) : 5'(16 + k);
      imm = 12'(next_rand());
      issue_one(lane, op_addi, rd, 5'd0, 5'd0, imm, ok);
    end
    for (int k = 0; k < n_random && ok; k++) begin
      op  = op_e'(next_rand() % 12);
      rd  = pick_reg(lane, 16);
      rs1 = pick_reg(lane, 8);
      rs2 = pick_reg(lane, 8);
      imm = 12'(next_rand());
      issue_one(lane, op, rd, rs1, rs2, imm, ok);
      gap = next_rand() % 3;
      repeat (gap) @(posedge clk_i);
    end
  endtask

  // sample at negedge, outputs settled
  task automatic watch_lane(input int lane);
    cluster_pkg::result_t want;
    int idle;
    idle = 0;
    while (received[lane] < planned[lane] && idle < wait_limit) begin
      @(negedge clk_i);
      idle++;
      if (instr_credit_o[lane]) begin
        popped[lane]++;
        in_cred[lane]++;
        checks++;
        assert (popped[lane] <= pushed[lane]) else begin
          $display("ERR %0t: lane %0d returned %0d credits for %0d instructions",
                   $time, lane, popped[lane], pushed[lane]);
          errors++;
        end
      end
      if (result_valid_o[lane]) begin
        idle = 0;
        checks++;
        assert (res_cred[lane] > 0) else begin
          $display("ERR %0t: lane %0d sent a result with no credit", $time, lane);
          errors++;
        end
        res_cred[lane]--;
        owed[lane]++;
        received[lane]++;
        checks++;
        assert (want_q[lane].size() != 0) else begin
          $display("ERR %0t: lane %0d sent an unexpected result", $time, lane);
          errors++;
        end
        if (want_q[lane].size() != 0) begin
          want = want_q[lane].pop_front();
          checks++;
          assert (result_o[lane] == want) else begin
            $display("ERR %0t: lane %0d got rd=%0d value=%h, expected rd=%0d value=%h",
                     $time, lane, result_o[lane].rd, result_o[lane].value,
                     want.rd, want.value);
            errors++;
          end
        end
      end
      // credit seen by the lane at the next edge
      if (result_credit_i[lane]) begin
        res_cred[lane]++;
      end
    end
    if (received[lane] < planned[lane]) begin
      $display("timeout: lane %0d delivered only %0d of %0d results",
               lane, received[lane], planned[lane]);
      timeouts++;
    end
    lane_done[lane] = 1'b1;
  endtask

  // hand credits back, sometimes after a long stall
  task automatic return_credits(input int lane);
    int hold;
    int cycles;
    hold   = 0;
    cycles = 0;
    while (!lane_done[lane] && cycles < run_limit) begin
      @(posedge clk_i);
      cycles++;
      result_credit_i[lane] <= 1'b0;
      if (hold > 0) begin
        hold--;
      end else if (owed[lane] > 0) begin
        result_credit_i[lane] <= 1'b1;
        owed[lane]--;
        hold = (next_rand() % 8 == 0) ? 20 + next_rand() % 40 : next_rand() % 3;
      end
    end
    result_credit_i[lane] <= 1'b0;
  endtask

  initial begin
    rng_state       = 32'd49607;
    errors          = 0;
    checks          = 0;
    timeouts        = 0;
    rst_n_i         = 1'b0;
    instr_valid_i   = '0;
    result_credit_i = '0;
    for (int l = 0; l < cluster_pkg::num_lanes; l++) begin
      instr_i[l]   = '0;
      in_cred[l]   = cluster_pkg::instr_credits;
      res_cred[l]  = cluster_pkg::result_credits;
      pushed[l]    = 0;
      popped[l]    = 0;
      received[l]  = 0;
      owed[l]      = 0;
      lane_done[l] = 1'b0;
      planned[l]   = ((l == 0) ? 15 : 16) + n_random;
    end
    for (int r = 0; r < rv32_isa_pkg::num_regs; r++) begin
      regs[r] = '0;
    end
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    fork
      issue_lane(0);
      issue_lane(1);
      watch_lane(0);
      watch_lane(1);
      return_credits(0);
      return_credits(1);
    join
    // nothing more may come out
    repeat (50) begin
      @(negedge clk_i);
      for (int l = 0; l < cluster_pkg::num_lanes; l++) begin
        checks++;
        assert (!result_valid_o[l]) else begin
          $display("ERR %0t: lane %0d sent an extra result", $time, l);
          errors++;
        end
      end
    end
    for (int l = 0; l < cluster_pkg::num_lanes; l++) begin
      checks++;
      assert (want_q[l].size() == 0 && received[l] == pushed[l]) else begin
        $display("ERR %0t: lane %0d issued %0d but delivered %0d results",
                 $time, l, pushed[l], received[l]);
        errors++;
      end
    end
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rv32_regfile_cluster.sv */
`default_nettype none

module rv32_regfile_cluster (
  input  wire logic                                clk_i,
  input  wire logic                                rst_n_i,
  input  wire logic [cluster_pkg::num_lanes-1:0]   instr_valid_i,
  input  wire rv32_isa_pkg::instr_u                instr_i [cluster_pkg::num_lanes],
  output wire logic [cluster_pkg::num_lanes-1:0]   instr_credit_o,
  output wire logic [cluster_pkg::num_lanes-1:0]   result_valid_o,
  output wire cluster_pkg::result_t                result_o [cluster_pkg::num_lanes],
  input  wire logic [cluster_pkg::num_lanes-1:0]   result_credit_i
);

  // lane side of the arbiter
  wire cluster_pkg::rf_req_t lane_req [cluster_pkg::num_lanes];
  wire cluster_pkg::rf_rsp_t lane_rsp [cluster_pkg::num_lanes];

  // register file side
  wire cluster_pkg::rf_req_t rf_req;
  wire cluster_pkg::rf_rsp_t rf_rsp;

  // identical lanes, the index picks the bank
  for (genvar g = 0; g < cluster_pkg::num_lanes; g++) begin : g_lane
    alu_lane u_lane (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .lane_id_i       (cluster_pkg::lane_idx_t'(g)),
      .instr_valid_i   (instr_valid_i[g]),
      .instr_i         (instr_i[g]),
      .instr_credit_o  (instr_credit_o[g]),
      .rf_req_o        (lane_req[g]),
      .rf_rsp_i        (lane_rsp[g]),
      .result_valid_o  (result_valid_o[g]),
      .result_o        (result_o[g]),
      .result_credit_i (result_credit_i[g])
    );
  end

  // single access slot per cycle
  regfile_arbiter u_arbiter (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .lane_req_i (lane_req),
    .lane_rsp_o (lane_rsp),
    .rf_req_o   (rf_req),
    .rf_rsp_i   (rf_rsp)
  );

  rv32im_registers u_registers (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .rf_req_i (rf_req),
    .rf_rsp_o (rf_rsp)
  );

endmodule

`default_nettype wire

/* alu_lane.sv */
`default_nettype none

module alu_lane (
  input  wire logic                    clk_i,
  input  wire logic                    rst_n_i,
  input  wire cluster_pkg::lane_idx_t  lane_id_i,
  input  wire logic                    instr_valid_i,
  input  wire rv32_isa_pkg::instr_u    instr_i,
  output logic                         instr_credit_o,
  output cluster_pkg::rf_req_t         rf_req_o,
  input  wire cluster_pkg::rf_rsp_t    rf_rsp_i,
  output logic                         result_valid_o,
  output cluster_pkg::result_t         result_o,
  input  wire logic                    result_credit_i
);

  typedef enum logic [2:0] {
    st_idle,
    st_read,
    st_wait,
    st_write,
    st_emit
  } state_e;

  state_e                        state_q;

  // input buffer
  logic [rv32_isa_pkg::xlen-1:0] buf_q [cluster_pkg::instr_credits];
  cluster_pkg::instr_ptr_t       wr_ptr_q;
  cluster_pkg::instr_ptr_t       rd_ptr_q;
  cluster_pkg::instr_cnt_t       count_q;
  logic                          push;
  logic                          pop;

  // instruction in flight and its result
  rv32_isa_pkg::instr_u          cur_q;
  logic [rv32_isa_pkg::xlen-1:0] value_q;
  cluster_pkg::result_cnt_t      cred_q;

  // alu
  logic                          is_reg;
  logic                          is_imm;
  logic [rv32_isa_pkg::xlen-1:0] imm_ext;
  logic [rv32_isa_pkg::xlen-1:0] op_a;
  logic [rv32_isa_pkg::xlen-1:0] op_b;
  logic [rv32_isa_pkg::xlen-1:0] alu_out;

  // a register lies in this lane's bank, or is x0
  function automatic logic in_bank(input logic [rv32_isa_pkg::reg_bits-1:0] addr,
                                   input cluster_pkg::lane_idx_t lane);
    return (addr == '0) ||
           (addr[rv32_isa_pkg::reg_bits-1:cluster_pkg::bank_shift] == lane);
  endfunction

  // source only pushes with a credit in hand
  assign push = instr_valid_i;
  // next instruction leaves the buffer once the lane is idle
  assign pop  = (state_q == st_idle) && (count_q != '0);

  always_ff @(posedge clk_i) begin
    if (push) begin
      buf_q[wr_ptr_q] <= instr_i.raw;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q       <= '0;
      rd_ptr_q       <= '0;
      count_q        <= '0;
      instr_credit_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == cluster_pkg::instr_last) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == cluster_pkg::instr_last) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
      // freed slot goes back to the source
      instr_credit_o <= pop;
    end
  end

  // decode, both formats keep opcode, rd, funct3 and rs1 in place
  assign is_reg  = (cur_q.r.opcode == rv32_isa_pkg::op_reg);
  assign is_imm  = (cur_q.r.opcode == rv32_isa_pkg::op_imm);
  assign imm_ext = {{(rv32_isa_pkg::xlen - rv32_isa_pkg::imm_bits){cur_q.i.imm12[11]}},
                    cur_q.i.imm12};
  assign op_a    = rf_rsp_i.rs1_data;
  assign op_b    = is_reg ? rf_rsp_i.rs2_data : imm_ext;

  always_comb begin
    alu_out = '0;
    if (is_reg && (cur_q.r.funct7 == rv32_isa_pkg::f7_muldiv) &&
        (cur_q.r.funct3 == rv32_isa_pkg::f3_mul)) begin
      // low word of the product
      alu_out = op_a * op_b;
    end else if (is_reg || is_imm) begin
      case (cur_q.r.funct3)
        rv32_isa_pkg::f3_add_sub: begin
          if (is_reg && (cur_q.r.funct7 == rv32_isa_pkg::f7_sub)) begin
            alu_out = op_a - op_b;
          end else begin
            alu_out = op_a + op_b;
          end
        end
        rv32_isa_pkg::f3_sll: alu_out = op_a << op_b[rv32_isa_pkg::shamt_bits-1:0];
        rv32_isa_pkg::f3_srl: alu_out = op_a >> op_b[rv32_isa_pkg::shamt_bits-1:0];
        rv32_isa_pkg::f3_xor: alu_out = op_a ^ op_b;
        rv32_isa_pkg::f3_or:  alu_out = op_a | op_b;
        rv32_isa_pkg::f3_and: alu_out = op_a & op_b;
        default:              alu_out = '0;
      endcase
    end
  end

  // instruction and result payload
  always_ff @(posedge clk_i) begin
    if (pop) begin
      cur_q.raw <= buf_q[rd_ptr_q];
    end
    // operands are on rf_rsp_i only during st_wait
    if (state_q == st_wait) begin
      value_q <= alu_out;
    end
  end

  // idle, read, wait data, write, emit
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= st_idle;
    end else begin
      case (state_q)
        st_idle:  if (pop)             state_q <= st_read;
        st_read:  if (rf_rsp_i.grant)  state_q <= st_wait;
        st_wait:                       state_q <= st_write;
        st_write: if (rf_rsp_i.grant)  state_q <= st_emit;
        st_emit:  if (cred_q != '0)    state_q <= st_idle;
        default:                       state_q <= st_idle;
      endcase
    end
  end

  // fields stay fixed while a request waits for grant
  always_comb begin
    rf_req_o       = '0;
    rf_req_o.req   = (state_q == st_read) || (state_q == st_write);
    rf_req_o.we    = (state_q == st_write);
    rf_req_o.rs1   = cur_q.r.rs1;
    // I-type has no rs2, keep the port on x0
    rf_req_o.rs2   = is_reg ? cur_q.r.rs2 : '0;
    rf_req_o.rd    = cur_q.r.rd;
    rf_req_o.wdata = value_q;
  end

  // one pulse per result, only while a credit is held
  assign result_valid_o = (state_q == st_emit) && (cred_q != '0);
  assign result_o.rd    = cur_q.r.rd;
  assign result_o.value = value_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cred_q <= cluster_pkg::result_init;
    end else if (result_credit_i && !result_valid_o) begin
      cred_q <= cred_q + 1'b1;
    end else if (result_valid_o && !result_credit_i) begin
      cred_q <= cred_q - 1'b1;
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push |-> (count_q != cluster_pkg::instr_full))
    else $error("source credit violation, push into full buffer");

  // bank rule keeps the lanes independent
  a_own_bank: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rf_req_o.req |-> (in_bank(rf_req_o.rs1, lane_id_i) &&
                      in_bank(rf_req_o.rs2, lane_id_i) &&
                      in_bank(rf_req_o.rd, lane_id_i)))
    else $error("lane %0d touched a register outside its bank", lane_id_i);

endmodule

`default_nettype wire

/* regfile_arbiter.sv */
`default_nettype none

module regfile_arbiter (
  input  wire logic                  clk_i,
  input  wire logic                  rst_n_i,
  input  wire cluster_pkg::rf_req_t  lane_req_i [cluster_pkg::num_lanes],
  output cluster_pkg::rf_rsp_t       lane_rsp_o [cluster_pkg::num_lanes],
  output cluster_pkg::rf_req_t       rf_req_o,
  input  wire cluster_pkg::rf_rsp_t  rf_rsp_i
);

  logic [cluster_pkg::num_lanes-1:0] grant;
  logic                              win_valid;
  cluster_pkg::lane_idx_t            win_idx;
  // lane with first claim this cycle
  cluster_pkg::lane_idx_t            prio_q;
  // one-hot owner of the read data arriving next cycle
  logic [cluster_pkg::num_lanes-1:0] owner_q;

  // round robin, search starts at prio_q
  always_comb begin
    cluster_pkg::lane_idx_t idx;
    grant     = '0;
    win_valid = 1'b0;
    win_idx   = '0;
    idx       = prio_q;
    for (int i = 0; i < cluster_pkg::num_lanes; i++) begin
      if (!win_valid && lane_req_i[idx].req) begin
        grant[idx] = 1'b1;
        win_valid  = 1'b1;
        win_idx    = idx;
      end
      idx = (idx == cluster_pkg::last_lane) ? '0 : idx + 1'b1;
    end
  end

  // winner goes straight through, no added cycle
  assign rf_req_o = win_valid ? lane_req_i[win_idx] : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prio_q  <= '0;
      owner_q <= '0;
    end else begin
      // priority moves past the last winner
      if (win_valid) begin
        prio_q <= (win_idx == cluster_pkg::last_lane) ? '0 : win_idx + 1'b1;
      end
      // only reads return data
      owner_q <= (win_valid && !rf_req_o.we) ? grant : '0;
    end
  end

  // grant now, data to the owner one cycle later
  always_comb begin
    for (int i = 0; i < cluster_pkg::num_lanes; i++) begin
      lane_rsp_o[i].grant    = grant[i];
      lane_rsp_o[i].rs1_data = owner_q[i] ? rf_rsp_i.rs1_data : '0;
      lane_rsp_o[i].rs2_data = owner_q[i] ? rf_rsp_i.rs2_data : '0;
    end
  end

  a_grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(grant))
    else $error("more than one lane granted");

  // lanes must keep a waiting request steady
  for (genvar g = 0; g < cluster_pkg::num_lanes; g++) begin : g_hold
    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (lane_req_i[g].req && !grant[g]) |=> $stable(lane_req_i[g]))
      else $error("lane %0d changed a pending request", g);
  end

endmodule

`default_nettype wire

/* rv32im_registers.sv */
`default_nettype none

module rv32im_registers (
  input  wire logic                  clk_i,
  input  wire logic                  rst_n_i,
  input  wire cluster_pkg::rf_req_t  rf_req_i,
  output cluster_pkg::rf_rsp_t       rf_rsp_o
);

  logic                          bram_we;
  logic                          bram_re;
  logic [rv32_isa_pkg::xlen-1:0] rs1_q;
  logic [rv32_isa_pkg::xlen-1:0] rs2_q;
  logic                          rs1_zero_q;
  logic                          rs2_zero_q;

  // x0 is never stored
  assign bram_we = rf_req_i.req && rf_req_i.we && (rf_req_i.rd != '0);
  assign bram_re = rf_req_i.req && !rf_req_i.we;

  // copy feeding rs1
  bram_dual_re u_rs1_bram (
    .clk_i   (clk_i),
    .write_i (bram_we),
    .read_i  (bram_re),
    .waddr_i (rf_req_i.rd),
    .raddr_i (rf_req_i.rs1),
    .data_i  (rf_req_i.wdata),
    .data_o  (rs1_q)
  );

  // copy feeding rs2, same write stream
  bram_dual_re u_rs2_bram (
    .clk_i   (clk_i),
    .write_i (bram_we),
    .read_i  (bram_re),
    .waddr_i (rf_req_i.rd),
    .raddr_i (rf_req_i.rs2),
    .data_i  (rf_req_i.wdata),
    .data_o  (rs2_q)
  );

  // x0 flags follow the bram read latency
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rs1_zero_q <= 1'b1;
      rs2_zero_q <= 1'b1;
    end else if (bram_re) begin
      rs1_zero_q <= (rf_req_i.rs1 == '0);
      rs2_zero_q <= (rf_req_i.rs2 == '0);
    end
  end

  // grant is the arbiter's business
  always_comb begin
    rf_rsp_o.grant    = 1'b0;
    rf_rsp_o.rs1_data = rs1_zero_q ? '0 : rs1_q;
    rf_rsp_o.rs2_data = rs2_zero_q ? '0 : rs2_q;
  end

  // x0 reads back as zero one cycle after the read, whatever was aimed at it
  a_x0_rs1_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (bram_re && (rf_req_i.rs1 == '0)) |=> (rf_rsp_o.rs1_data == '0))
    else $error("read of x0 on the rs1 port returned nonzero data");

  a_x0_rs2_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (bram_re && (rf_req_i.rs2 == '0)) |=> (rf_rsp_o.rs2_data == '0))
    else $error("read of x0 on the rs2 port returned nonzero data");

endmodule

`default_nettype wire

/* bram_dual_re.sv */
`default_nettype none

module bram_dual_re (
  input  wire logic                                clk_i,
  input  wire logic                                write_i,
  input  wire logic                                read_i,
  input  wire logic [rv32_isa_pkg::reg_bits-1:0]   waddr_i,
  input  wire logic [rv32_isa_pkg::reg_bits-1:0]   raddr_i,
  input  wire logic [rv32_isa_pkg::xlen-1:0]       data_i,
  output logic      [rv32_isa_pkg::xlen-1:0]       data_o
);

  // plain storage, maps onto a block ram
  logic [rv32_isa_pkg::xlen-1:0] mem [rv32_isa_pkg::num_regs];

  // write port
  always_ff @(posedge clk_i) begin
    if (write_i) begin
      mem[waddr_i] <= data_i;
    end
  end

  // read port, output register holds while read_i is low
  // same-address collision gives the old word
  always_ff @(posedge clk_i) begin
    if (read_i) begin
      data_o <= mem[raddr_i];
    end
  end

endmodule

`default_nettype wire

/* cluster_pkg.sv */
`default_nettype none

package cluster_pkg;

  // two lanes share the register file
  localparam int unsigned num_lanes = 2;
  localparam int unsigned lane_bits = $clog2(num_lanes);

  typedef logic [lane_bits-1:0] lane_idx_t;

  // wrap point of the round-robin pointer
  localparam lane_idx_t last_lane = lane_idx_t'(num_lanes - 1);

  // register bank of a lane is the top address bits
  localparam int unsigned bank_shift = rv32_isa_pkg::reg_bits - lane_bits;

  // instruction input buffer, one slot per source credit
  localparam int unsigned instr_credits  = 2;
  localparam int unsigned instr_ptr_bits = $clog2(instr_credits);
  localparam int unsigned instr_cnt_bits = $clog2(instr_credits + 1);

  typedef logic [instr_ptr_bits-1:0] instr_ptr_t;
  typedef logic [instr_cnt_bits-1:0] instr_cnt_t;

  localparam instr_ptr_t instr_last = instr_ptr_t'(instr_credits - 1);
  localparam instr_cnt_t instr_full = instr_cnt_t'(instr_credits);

  // result slots granted by the consumer after reset
  localparam int unsigned result_credits  = 2;
  localparam int unsigned result_cnt_bits = $clog2(result_credits + 1);

  typedef logic [result_cnt_bits-1:0] result_cnt_t;

  localparam result_cnt_t result_init = result_cnt_t'(result_credits);

  // one register file access, read when we is low
  typedef struct packed {
    logic                                  req;
    logic                                  we;
    logic [rv32_isa_pkg::reg_bits-1:0]     rs1;
    logic [rv32_isa_pkg::reg_bits-1:0]     rs2;
    logic [rv32_isa_pkg::reg_bits-1:0]     rd;
    logic [rv32_isa_pkg::xlen-1:0]         wdata;
  } rf_req_t;

  // grant this cycle, read data one cycle after a read grant
  typedef struct packed {
    logic                          grant;
    logic [rv32_isa_pkg::xlen-1:0] rs1_data;
    logic [rv32_isa_pkg::xlen-1:0] rs2_data;
  } rf_rsp_t;

  // retired instruction as seen by the consumer
  typedef struct packed {
    logic [rv32_isa_pkg::reg_bits-1:0] rd;
    logic [rv32_isa_pkg::xlen-1:0]     value;
  } result_t;

endpackage

`default_nettype wire

/* rv32_isa_pkg.sv */
`default_nettype none

package rv32_isa_pkg;

  // datapath width
  localparam int unsigned xlen = 32;

  // register address width, 32 architectural registers
  localparam int unsigned reg_bits = 5;
  localparam int unsigned num_regs = 1 << reg_bits;

  // only the low five bits of rs2 count as a shift amount
  localparam int unsigned shamt_bits = 5;

  // i-type immediate width
  localparam int unsigned imm_bits = 12;

  // major opcodes
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_imm = 7'b0010011;

  // funct3 values, shared by the R-type and I-type forms
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl     = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;
  // M extension multiply sits on funct3 000 as well
  localparam logic [2:0] f3_mul     = 3'b000;

  // funct7 selects sub and the M extension
  localparam logic [6:0] f7_sub    = 7'b0100000;
  localparam logic [6:0] f7_muldiv = 7'b0000001;

  // R-type layout, msb first
  typedef struct packed {
    logic [6:0]          funct7;
    logic [reg_bits-1:0] rs2;
    logic [reg_bits-1:0] rs1;
    logic [2:0]          funct3;
    logic [reg_bits-1:0] rd;
    logic [6:0]          opcode;
  } r_type_t;

  // I-type layout, immediate replaces funct7 and rs2
  typedef struct packed {
    logic [imm_bits-1:0] imm12;
    logic [reg_bits-1:0] rs1;
    logic [2:0]          funct3;
    logic [reg_bits-1:0] rd;
    logic [6:0]          opcode;
  } i_type_t;

  // one instruction word, seen either way
  typedef union packed {
    r_type_t         r;
    i_type_t         i;
    logic [xlen-1:0] raw;
  } instr_u;

endpackage

`default_nettype wire
